// File: common/wb_bus_pkg.sv
// wishbone bus widths and the request/response bundles shared by all ports
package wb_bus_pkg;

	localparam int ADDR_HI = 31;  // word address, byte offset bits dropped
	localparam int ADDR_LO = 2;
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;

	// everything a master drives towards a slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic [ADDR_HI:ADDR_LO] adr;
		logic [2:0] cti;  // carried only, slaves treat every cycle as classic
		logic [1:0] bte;
		logic [SEL_W-1:0] sel;
		logic we;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

	// everything a slave drives back
	typedef struct packed {
		logic [DATA_W-1:0] dat;
		logic ack;
		logic err;
	} wb_rsp_t;

endpackage

// File: common/soc_map_pkg.sv
// soc address map: slave select, window fields and rom content
package soc_map_pkg;

	typedef enum logic [1:0] {
		SLV_RAM = 2'd0,
		SLV_ROM = 2'd1,
		SLV_IO = 2'd2
	} slave_e;

	localparam int SLV_COUNT = 3;
	localparam logic [7:0] HI_TAG = 8'hff;  // byte value that leaves the ram window

	// i/o window offset is the word address below the two tag bytes
	localparam int IO_OFS_HI = 15;
	localparam int IO_REG_COUNT = 4;

	// top byte not all ones -> ram, then second byte not all ones -> rom, else i/o
	function automatic slave_e decode(input logic [wb_bus_pkg::ADDR_HI:wb_bus_pkg::ADDR_LO] adr);
		if (adr[31:24] != HI_TAG)
			return SLV_RAM;
		if (adr[23:16] != HI_TAG)
			return SLV_ROM;
		return SLV_IO;
	endfunction

	// fixed rom pattern, byte address rotated right by 13 and inverted
	function automatic logic [31:0] rom_word(input logic [wb_bus_pkg::ADDR_HI:wb_bus_pkg::ADDR_LO] adr);
		logic [31:0] w;
		w = {adr, 2'b00};
		return ~{w[12:0], w[31:13]};
	endfunction

endpackage

// File: hdl/bit_searcher.sv
`timescale 1ns/1ns

// finds the lowest set bit, so bit 0 has the highest priority
module bit_searcher #(
	parameter int N = 4
) (
	input logic [N-1:0] bits_i,
	output logic hit_o,
	output logic [$clog2(N)-1:0] index_o
);

	always_comb begin
		hit_o = 1'b0;
		index_o = '0;
		// walk downwards so the last match is the lowest index
		for (int i = N - 1; i >= 0; i--) begin
			if (bits_i[i]) begin
				hit_o = 1'b1;
				index_o = i[$clog2(N)-1:0];
			end
		end
	end

endmodule

// File: wb_arb/wb_arb.sv
`timescale 1ns/1ns

// fixed priority wishbone arbiter, m0 > m1 > ..., with address decode to three slaves
module wb_arb #(
	parameter int N_MASTERS = 4
) (
	input logic wb_clk,
	input logic wb_rst,
	input wb_bus_pkg::wb_req_t m_req_i [N_MASTERS],
	output wb_bus_pkg::wb_rsp_t m_rsp_o [N_MASTERS],
	output wb_bus_pkg::wb_req_t s_req_o [soc_map_pkg::SLV_COUNT],
	input wb_bus_pkg::wb_rsp_t s_rsp_i [soc_map_pkg::SLV_COUNT]
);

	localparam int MW = $clog2(N_MASTERS);

	logic [N_MASTERS-1:0] cyc_bits;
	logic next_vld;
	logic [MW-1:0] next_m;
	logic curr_vld;  // a master owns the bus
	logic [MW-1:0] curr_m;
	logic [MW-1:0] master;  // master being routed this cycle
	logic route_en;
	wb_bus_pkg::wb_req_t m_req;
	wb_bus_pkg::wb_rsp_t m_rsp;
	soc_map_pkg::slave_e slv;
	logic [soc_map_pkg::SLV_COUNT-1:0] slv_busy;  // slave answering this cycle

	always_comb begin
		for (int i = 0; i < N_MASTERS; i++) begin
			cyc_bits[i] = m_req_i[i].cyc;
		end
	end

	bit_searcher #(
		.N(N_MASTERS)
	) i_prio (
		.bits_i(cyc_bits),
		.hit_o(next_vld),
		.index_o(next_m)
	);

	// grant is only re-evaluated while idle or once the owner has dropped cyc
	always_ff @(posedge wb_clk) begin
		if (wb_rst) begin
			curr_vld <= 1'b0;
			curr_m <= '0;
		end else if (!curr_vld || !m_req.cyc) begin
			curr_vld <= next_vld;
			curr_m <= next_m;
		end
	end

	assign master = curr_vld ? curr_m : next_m;  // idle bus routes the winner at once
	assign route_en = curr_vld || next_vld;

	always_comb begin
		m_req = '0;
		if (route_en)
			m_req = m_req_i[master];
	end

	assign slv = soc_map_pkg::decode(m_req.adr);

	// request to the decoded slave only
	always_comb begin
		for (int s = 0; s < soc_map_pkg::SLV_COUNT; s++) begin
			s_req_o[s] = '0;
		end
		if (route_en)
			s_req_o[slv] = m_req;
	end

	always_comb begin
		m_rsp = '0;
		if (route_en)
			m_rsp = s_rsp_i[slv];
	end

	// response back to the routed master, others see nothing
	always_comb begin
		for (int i = 0; i < N_MASTERS; i++) begin
			m_rsp_o[i] = '0;
		end
		if (route_en)
			m_rsp_o[master] = m_rsp;
	end

	always_comb begin
		for (int s = 0; s < soc_map_pkg::SLV_COUNT; s++) begin
			slv_busy[s] = s_rsp_i[s].ack || s_rsp_i[s].err;
		end
	end

	a_one_slave: assert property (@(posedge wb_clk) disable iff (wb_rst)
		$onehot0(slv_busy));

	for (genvar g = 0; g < N_MASTERS; g++) begin : g_rsp_chk
		a_ack_xor_err: assert property (@(posedge wb_clk) disable iff (wb_rst)
			!(m_rsp_o[g].ack && m_rsp_o[g].err));
		// only the registered owner ever hears back
		a_rsp_to_owner: assert property (@(posedge wb_clk) disable iff (wb_rst)
			m_rsp_o[g].ack || m_rsp_o[g].err |-> curr_vld && int'(curr_m) == g);
	end

endmodule

// File: hdl/wb_ram.sv
`timescale 1ns/1ns

// word ram slave, one cycle ack, wraps on the low address bits
module wb_ram #(
	parameter int RAM_WORDS = 256
) (
	input logic wb_clk,
	input logic wb_rst,
	input wb_bus_pkg::wb_req_t req_i,
	output wb_bus_pkg::wb_rsp_t rsp_o
);

	localparam int AW = $clog2(RAM_WORDS);

	logic [wb_bus_pkg::DATA_W-1:0] mem [RAM_WORDS];
	logic [AW-1:0] idx;
	logic start;
	logic ack_q;
	logic [wb_bus_pkg::DATA_W-1:0] rdat_q;

	assign idx = req_i.adr[wb_bus_pkg::ADDR_LO +: AW];  // upper bits alias
	assign start = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge wb_clk) begin
		if (wb_rst)
			ack_q <= 1'b0;
		else
			ack_q <= start;
	end

	always_ff @(posedge wb_clk) begin
		if (start) begin
			if (req_i.we) begin
				for (int b = 0; b < wb_bus_pkg::SEL_W; b++) begin
					if (req_i.sel[b])
						mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
				end
			end
			rdat_q <= mem[idx];  // old word, only looked at on reads
		end
	end

	assign rsp_o.dat = rdat_q;
	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;

	// the ack belongs to the request still on the bus
	a_req_held: assert property (@(posedge wb_clk) disable iff (wb_rst)
		ack_q |-> req_i.cyc && req_i.stb);

endmodule

// File: hdl/wb_rom.sv
`timescale 1ns/1ns

// read only slave, content comes from the address map function
module wb_rom (
	input logic wb_clk,
	input logic wb_rst,
	input wb_bus_pkg::wb_req_t req_i,
	output wb_bus_pkg::wb_rsp_t rsp_o
);

	logic start;
	logic ack_q;
	logic err_q;
	logic [wb_bus_pkg::DATA_W-1:0] rdat_q;

	assign start = req_i.cyc && req_i.stb && !(ack_q || err_q);

	always_ff @(posedge wb_clk) begin
		if (wb_rst) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= start && !req_i.we;
			err_q <= start && req_i.we;  // writes are refused
		end
	end

	always_ff @(posedge wb_clk) begin
		if (start)
			rdat_q <= soc_map_pkg::rom_word(req_i.adr);
	end

	assign rsp_o.dat = rdat_q;
	assign rsp_o.ack = ack_q;
	assign rsp_o.err = err_q;

endmodule

// File: hdl/wb_io_regs.sv
`timescale 1ns/1ns

// four read/write control registers, err on any other offset of the window
module wb_io_regs (
	input logic wb_clk,
	input logic wb_rst,
	input wb_bus_pkg::wb_req_t req_i,
	output wb_bus_pkg::wb_rsp_t rsp_o,
	output logic [soc_map_pkg::IO_REG_COUNT-1:0][wb_bus_pkg::DATA_W-1:0] regs_o
);

	localparam int RW = $clog2(soc_map_pkg::IO_REG_COUNT);

	logic [soc_map_pkg::IO_OFS_HI:wb_bus_pkg::ADDR_LO] ofs;
	logic [RW-1:0] ridx;
	logic mapped;
	logic start;
	logic ack_q;
	logic err_q;
	logic [wb_bus_pkg::DATA_W-1:0] rdat_q;

	assign ofs = req_i.adr[soc_map_pkg::IO_OFS_HI:wb_bus_pkg::ADDR_LO];
	assign ridx = ofs[wb_bus_pkg::ADDR_LO +: RW];
	assign mapped = ofs < soc_map_pkg::IO_REG_COUNT;
	assign start = req_i.cyc && req_i.stb && !(ack_q || err_q);

	always_ff @(posedge wb_clk) begin
		if (wb_rst) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
			regs_o <= '0;
		end else begin
			ack_q <= start && mapped;
			err_q <= start && !mapped;
			if (start && mapped && req_i.we) begin
				for (int b = 0; b < wb_bus_pkg::SEL_W; b++) begin
					if (req_i.sel[b])
						regs_o[ridx][8*b +: 8] <= req_i.dat[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge wb_clk) begin
		if (start)
			rdat_q <= mapped ? regs_o[ridx] : '0;
	end

	assign rsp_o.dat = rdat_q;
	assign rsp_o.ack = ack_q;
	assign rsp_o.err = err_q;

endmodule

// File: hdl/wb_soc_bus.sv
`timescale 1ns/1ns

// soc bus: arbiter in front of ram, rom and i/o registers
module wb_soc_bus #(
	parameter int N_MASTERS = 4,
	parameter int RAM_WORDS = 256
) (
	input logic wb_clk,
	input logic wb_rst,
	input wb_bus_pkg::wb_req_t m_req_i [N_MASTERS],
	output wb_bus_pkg::wb_rsp_t m_rsp_o [N_MASTERS],
	output logic [soc_map_pkg::IO_REG_COUNT-1:0][wb_bus_pkg::DATA_W-1:0] io_regs_o
);

	wb_bus_pkg::wb_req_t s_req [soc_map_pkg::SLV_COUNT];
	wb_bus_pkg::wb_rsp_t s_rsp [soc_map_pkg::SLV_COUNT];

	wb_arb #(
		.N_MASTERS(N_MASTERS)
	) i_arb (
		.wb_clk(wb_clk),
		.wb_rst(wb_rst),
		.m_req_i(m_req_i),
		.m_rsp_o(m_rsp_o),
		.s_req_o(s_req),
		.s_rsp_i(s_rsp)
	);

	wb_ram #(
		.RAM_WORDS(RAM_WORDS)
	) i_ram (
		.wb_clk(wb_clk),
		.wb_rst(wb_rst),
		.req_i(s_req[soc_map_pkg::SLV_RAM]),
		.rsp_o(s_rsp[soc_map_pkg::SLV_RAM])
	);

	wb_rom i_rom (
		.wb_clk(wb_clk),
		.wb_rst(wb_rst),
		.req_i(s_req[soc_map_pkg::SLV_ROM]),
		.rsp_o(s_rsp[soc_map_pkg::SLV_ROM])
	);

	wb_io_regs i_io (
		.wb_clk(wb_clk),
		.wb_rst(wb_rst),
		.req_i(s_req[soc_map_pkg::SLV_IO]),
		.rsp_o(s_rsp[soc_map_pkg::SLV_IO]),
		.regs_o(io_regs_o)
	);

endmodule

// File: dv/tb_wb_soc_bus.sv
`timescale 1ns/1ns

// random traffic from four masters, checked against ram, rom, register and grant models
module tb_wb_soc_bus;

	localparam int N_MASTERS = 4;
	localparam int RAM_WORDS = 256;
	localparam int NXFER = 48;  // transfers per master
	localparam int RST_CYCLES = 16;
	localparam logic [31:0] SEED = 32'h19500013;
	localparam int T_RAM = 0;
	localparam int T_ROM = 1;
	localparam int T_IO = 2;
	localparam int T_PRIO = 3;
	localparam int T_HOLD = 4;
	localparam int N_TESTS = 5;

	logic wb_clk;
	logic wb_rst;
	wb_bus_pkg::wb_req_t m_req [N_MASTERS];
	wb_bus_pkg::wb_rsp_t m_rsp [N_MASTERS];
	logic [soc_map_pkg::IO_REG_COUNT-1:0][31:0] io_regs;

	logic [31:0] lfsr_state [N_MASTERS];  // one stream per master
	logic [31:0] ram_img [int];
	logic [31:0] io_img [soc_map_pkg::IO_REG_COUNT];
	int checks [N_TESTS];
	int errors [N_TESTS];

	wb_soc_bus #(
		.N_MASTERS(N_MASTERS),
		.RAM_WORDS(RAM_WORDS)
	) i_dut (
		.wb_clk(wb_clk),
		.wb_rst(wb_rst),
		.m_req_i(m_req),
		.m_rsp_o(m_rsp),
		.io_regs_o(io_regs)
	);

	always #50 wb_clk = ~wb_clk;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] take_bits(input int m, input int n);
		logic [31:0] s;
		logic [31:0] r;
		logic fb;
		s = lfsr_state[m];
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = s[31] ^ s[21] ^ s[1] ^ s[0];
			s = {s[30:0], fb};
			r = {r[30:0], fb};
		end
		lfsr_state[m] = s;
		return r;
	endfunction

	function automatic string test_name(input int t);
		case (t)
			T_RAM: return "ram";
			T_ROM: return "rom";
			T_IO: return "io";
			T_PRIO: return "priority";
			default: return "hold";
		endcase
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] r;
		r = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				r[8*b +: 8] = new_w[8*b +: 8];
		end
		return r;
	endfunction

	// master 0 wins, -1 when nobody asks
	function automatic int lowest_set(input logic [N_MASTERS-1:0] bits);
		for (int i = 0; i < N_MASTERS; i++) begin
			if (bits[i])
				return i;
		end
		return -1;
	endfunction

	task automatic check_value(input int test, input logic [31:0] expected,
			input logic [31:0] actual);
		checks[test]++;
		assert (actual === expected) else begin
			errors[test]++;
			$display("** Error %s: expected %h, actual %h", test_name(test), expected, actual);
		end
	endtask

	task automatic run_master(input int m);
		logic [31:0] baddr;
		logic [31:0] rnd;
		logic [31:0] dat;
		logic [3:0] sel;
		logic [3:0] word_lo;
		logic we;
		logic lock;
		int region;
		int key;
		int ofs;
		int gap;
		for (int t = 0; t < NXFER; t++) begin
			region = take_bits(m, 2);  // 0 and 1 ram, 2 rom, 3 i/o
			we = take_bits(m, 1);
			sel = take_bits(m, 4);
			dat = take_bits(m, 32);
			rnd = take_bits(m, 21);
			ofs = 0;
			case (region)
				2: baddr = {8'hff, 1'b0, rnd[20:0], 2'b00};
				3: begin
					if (take_bits(m, 2) == 0)
						ofs = take_bits(m, 14);  // mostly outside the four registers
					else
						ofs = take_bits(m, 2);
					baddr = {16'hffff, ofs[13:0], 2'b00};
				end
				default: begin
					word_lo = take_bits(m, 4);  // few words, so reads hit earlier writes
					baddr = {1'b0, rnd[20:0], 4'b0000, word_lo, 2'b00};
				end
			endcase
			key = (baddr >> 2) % RAM_WORDS;  // bits above the depth alias
			if (region < 2 && we && !ram_img.exists(key))
				sel = 4'hf;  // first write defines the whole word
			@(negedge wb_clk);
			m_req[m].cyc = 1'b1;
			m_req[m].stb = 1'b1;
			m_req[m].adr = baddr[31:2];
			m_req[m].sel = sel;
			m_req[m].we = we;
			m_req[m].dat = dat;
			do
				@(posedge wb_clk);
			while (!(m_rsp[m].ack || m_rsp[m].err));
			if (region < 2) begin
				check_value(T_RAM, 2'b10, {m_rsp[m].ack, m_rsp[m].err});
				if (we)
					ram_img[key] = merge_bytes(ram_img.exists(key) ? ram_img[key] : '0, dat, sel);
				else if (ram_img.exists(key))
					check_value(T_RAM, ram_img[key], m_rsp[m].dat);
			end else if (region == 2) begin
				if (we) begin
					check_value(T_ROM, 2'b01, {m_rsp[m].ack, m_rsp[m].err});
				end else begin
					check_value(T_ROM, 2'b10, {m_rsp[m].ack, m_rsp[m].err});
					check_value(T_ROM, soc_map_pkg::rom_word(baddr[31:2]), m_rsp[m].dat);
				end
			end else if (ofs >= soc_map_pkg::IO_REG_COUNT) begin
				check_value(T_IO, 2'b01, {m_rsp[m].ack, m_rsp[m].err});
				for (int i = 0; i < soc_map_pkg::IO_REG_COUNT; i++)
					check_value(T_IO, io_img[i], io_regs[i]);  // nothing may move
			end else begin
				check_value(T_IO, 2'b10, {m_rsp[m].ack, m_rsp[m].err});
				if (we) begin
					io_img[ofs] = merge_bytes(io_img[ofs], dat, sel);
					check_value(T_IO, io_img[ofs], io_regs[ofs]);
				end else begin
					check_value(T_IO, io_img[ofs], m_rsp[m].dat);
				end
			end
			@(negedge wb_clk);
			m_req[m].stb = 1'b0;
			lock = (t < NXFER - 1) && take_bits(m, 1);
			if (!lock) begin
				m_req[m].cyc = 1'b0;
				gap = take_bits(m, 2);
				repeat (gap) @(negedge wb_clk);
			end
		end
	endtask

	// grant model, sampled on the rising edge while the bus is settled
	initial begin
		logic [N_MASTERS-1:0] cyc;
		logic gvld;
		logic rvld;
		logic prio_wait;
		int gm;
		int rm;
		int low;
		int prio_m;
		gvld = 1'b0;
		gm = 0;
		prio_wait = 1'b0;
		prio_m = 0;
		@(negedge wb_rst);
		forever begin
			@(posedge wb_clk);
			for (int i = 0; i < N_MASTERS; i++)
				cyc[i] = m_req[i].cyc;
			low = lowest_set(cyc);
			rvld = gvld || low >= 0;
			rm = gvld ? gm : low;
			if (!gvld && $countones(cyc) > 1) begin
				prio_wait = 1'b1;
				prio_m = low;
			end
			for (int i = 0; i < N_MASTERS; i++) begin
				if (m_rsp[i].ack || m_rsp[i].err) begin
					check_value(T_HOLD, rvld ? 32'(rm) : 32'hffff_ffff, 32'(i));
					if (prio_wait) begin
						check_value(T_PRIO, 32'(prio_m), 32'(i));
						prio_wait = 1'b0;
					end
				end
			end
			if (!gvld || !cyc[gm]) begin  // owner gone, pick again
				gvld = low >= 0;
				gm = low >= 0 ? low : 0;
			end
		end
	end

	initial begin
		repeat (RST_CYCLES + N_MASTERS * NXFER * 40) @(posedge wb_clk);
		$display("watchdog: bus transfers still open after %0d cycles, run stopped",
			RST_CYCLES + N_MASTERS * NXFER * 40);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int total_checks;
		int total_errors;
		logic failed;
		wb_clk = 1'b0;
		wb_rst = 1'b1;
		for (int i = 0; i < N_MASTERS; i++)
			m_req[i] = '0;
		for (int i = 0; i < soc_map_pkg::IO_REG_COUNT; i++)
			io_img[i] = '0;
		lfsr_state[0] = SEED;
		for (int i = 1; i < N_MASTERS; i++)
			lfsr_state[i] = take_bits(i - 1, 32);  // each stream seeds the next
		repeat (RST_CYCLES) @(posedge wb_clk);
		@(negedge wb_clk);
		wb_rst = 1'b0;
		for (int i = 0; i < N_MASTERS; i++) begin
			fork
				automatic int k = i;
				run_master(k);
			join_none
		end
		wait fork;
		repeat (4) @(posedge wb_clk);
		total_checks = 0;
		total_errors = 0;
		failed = 1'b0;
		for (int t = 0; t < N_TESTS; t++) begin
			if (checks[t] == 0) begin
				$display("%s: no transfer of this kind was checked", test_name(t));
				failed = 1'b1;
			end else begin
				$display("%s: %0d checks, %0d errors", test_name(t), checks[t], errors[t]);
			end
			if (errors[t] != 0)
				failed = 1'b1;
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("total: %0d checks, %0d errors", total_checks, total_errors);
		if (failed)
			$display("TEST FAIL");
		else
			$display("TEST PASS");
		$finish;
	end

endmodule

// File: files.f
common/wb_bus_pkg.sv
common/soc_map_pkg.sv
hdl/bit_searcher.sv
wb_arb/wb_arb.sv
hdl/wb_ram.sv
hdl/wb_rom.sv
hdl/wb_io_regs.sv
hdl/wb_soc_bus.sv
dv/tb_wb_soc_bus.sv
